// ==== Bender.yml ====
package:
  name: ptp_td_leaf

sources:
  - src/ptp_td_pkg.sv
  - src/td_sdi_deser.sv
  - src/td_shadow_regs.sv
  - src/ts_rel_counter.sv
  - src/ts_tod_counter.sv
  - src/ptp_td_leaf.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ptp_td_leaf.sv

// ==== ptp_td_leaf.f ====
+incdir+tests
src/ptp_td_pkg.sv
src/td_sdi_deser.sv
src/td_shadow_regs.sv
src/ts_rel_counter.sv
src/ts_tod_counter.sv
src/ptp_td_leaf.sv
tests/tb_ptp_td_leaf.sv

// ==== src/ptp_td_leaf.sv ====
/*
 * PTP time distribution leaf receiver
 * rebuilds relative and time-of-day timestamps from the serial
 * distribution stream on a single clock
 */
`timescale 1ns/1ps

module ptp_td_leaf import ptp_td_pkg::*; #(
    parameter int SDI_PIPELINE = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ptp_td_sdi,
    output rel_ns_t ts_rel,
    output fns_t    ts_rel_fns,
    output logic    ts_rel_step,
    output tod_ns_t ts_tod_ns,
    output tod_s_t  ts_tod_s,
    output logic    ts_tod_step,
    output logic    pps
);

    // word stream
    td_word_t  word_data;
    td_index_t word_index;
    td_msg_t   word_msg;
    logic      word_last;
    logic      word_valid;

    // counter control
    period_t                period;
    logic                   rel_load;
    rel_ns_t                rel_load_ns;
    logic                   tod_load;
    tod_ns_t                tod_load_ns;
    tod_s_t                 tod_load_s;
    logic [PERIOD_NS_W:0]   ns_adv;

    td_sdi_deser #(
        .SDI_PIPELINE(SDI_PIPELINE)
    ) td_sdi_deser_inst (
        .clk        (clk),
        .rst        (rst),
        .ptp_td_sdi (ptp_td_sdi),
        .word_data  (word_data),
        .word_index (word_index),
        .word_msg   (word_msg),
        .word_last  (word_last),
        .word_valid (word_valid)
    );

    td_shadow_regs td_shadow_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .word_data   (word_data),
        .word_index  (word_index),
        .word_msg    (word_msg),
        .word_last   (word_last),
        .word_valid  (word_valid),
        .period      (period),
        .rel_load    (rel_load),
        .rel_load_ns (rel_load_ns),
        .tod_load    (tod_load),
        .tod_load_ns (tod_load_ns),
        .tod_load_s  (tod_load_s)
    );

    ts_rel_counter ts_rel_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .period      (period),
        .rel_load    (rel_load),
        .rel_load_ns (rel_load_ns),
        .ts_rel_ns   (ts_rel),
        .ts_rel_fns  (ts_rel_fns),
        .ts_rel_step (ts_rel_step),
        .ns_adv      (ns_adv)
    );

    ts_tod_counter ts_tod_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .ns_adv      (ns_adv),
        .tod_load    (tod_load),
        .tod_load_ns (tod_load_ns),
        .tod_load_s  (tod_load_s),
        .ts_tod_ns   (ts_tod_ns),
        .ts_tod_s    (ts_tod_s),
        .ts_tod_step (ts_tod_step),
        .pps         (pps)
    );

endmodule

// ==== src/ptp_td_pkg.sv ====
/*
 * PTP time distribution leaf, shared definitions
 * widths, field types, word positions within a time frame
 * and the one-second rollover constant
 */
package ptp_td_pkg;

    // serial word and timestamp widths
    localparam int WORD_W      = 16;
    localparam int FNS_W       = 16;
    localparam int REL_NS_W    = 48;
    localparam int TOD_NS_W    = 30;
    localparam int TOD_S_W     = 48;
    localparam int PERIOD_NS_W = 8;

    localparam logic [TOD_NS_W-1:0] NS_PER_S = 30'd1_000_000_000;

    typedef logic [WORD_W-1:0]            td_word_t;
    typedef logic [3:0]                   td_index_t;
    typedef logic [3:0]                   td_msg_t;
    typedef logic [FNS_W-1:0]             fns_t;
    typedef logic [REL_NS_W-1:0]          rel_ns_t;
    typedef logic [TOD_NS_W-1:0]          tod_ns_t;
    typedef logic [TOD_S_W-1:0]           tod_s_t;
    // integer ns in the upper bits, fraction below
    typedef logic [PERIOD_NS_W+FNS_W-1:0] period_t;

    // word positions in a time message
    localparam td_index_t IDX_HDR        = 4'd0;
    localparam td_index_t IDX_TOD_NS_LO  = 4'd1;
    localparam td_index_t IDX_TOD_NS_HI  = 4'd2;
    localparam td_index_t IDX_TOD_S_0    = 4'd3;
    localparam td_index_t IDX_TOD_S_1    = 4'd4;
    localparam td_index_t IDX_TOD_S_2    = 4'd5;
    localparam td_index_t IDX_REL_NS_0   = 4'd8;
    localparam td_index_t IDX_REL_NS_1   = 4'd9;
    localparam td_index_t IDX_REL_NS_2   = 4'd10;
    localparam td_index_t IDX_PERIOD_FNS = 4'd11;
    localparam td_index_t IDX_PERIOD_NS  = 4'd12;

    // step flags
    localparam int HDR_REL_STEP_BIT = 8;
    localparam int TOD_STEP_BIT     = 15;

    localparam td_msg_t MSG_TIME = 4'd0;

endpackage

// ==== src/td_sdi_deser.sv ====
/*
 * Serial time distribution deserializer
 * registers the line, collects start-framed 16-bit words LSB first
 * and emits them with their frame position and message type
 */
`timescale 1ns/1ps

module td_sdi_deser import ptp_td_pkg::*; #(
    parameter int SDI_PIPELINE = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      ptp_td_sdi,
    output td_word_t  word_data,
    output td_index_t word_index,
    output td_msg_t   word_msg,
    output logic      word_last,
    output logic      word_valid
);

    localparam logic [4:0] BIT_CNT_INIT = 5'(WORD_W);

    logic [SDI_PIPELINE-1:0] sdi_pipe;
    logic                    sdi_bit;
    td_word_t                shift_reg;
    logic [4:0]              bit_cnt;
    logic                    in_word;
    logic                    word_end;
    td_index_t               index_reg;
    td_msg_t                 msg_reg;

    assign sdi_bit  = sdi_pipe[SDI_PIPELINE-1];
    // the sample after the last data bit
    assign word_end = in_word && (bit_cnt == 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // line idles high
            sdi_pipe   <= '1;
            bit_cnt    <= 5'd0;
            in_word    <= 1'b0;
            word_valid <= 1'b0;
            index_reg  <= '0;
        end else begin
            sdi_pipe[0] <= ptp_td_sdi;
            for (int i = 1; i < SDI_PIPELINE; i++) begin
                sdi_pipe[i] <= sdi_pipe[i-1];
            end

            word_valid <= word_end;

            if (bit_cnt != 5'd0) begin
                bit_cnt <= bit_cnt - 5'd1;
            end else begin
                in_word <= ~sdi_bit;
                if (sdi_bit) begin
                    // stop or idle, next start opens a new frame
                    index_reg <= '0;
                end else begin
                    bit_cnt <= BIT_CNT_INIT;
                    if (in_word) begin
                        index_reg <= index_reg + 4'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= {sdi_bit, shift_reg[WORD_W-1:1]};

        if (word_end) begin
            word_data  <= shift_reg;
            word_last  <= sdi_bit;
            word_index <= index_reg;
            if (index_reg == IDX_HDR) begin
                // type rides along with the header word itself
                msg_reg  <= shift_reg[3:0];
                word_msg <= shift_reg[3:0];
            end else begin
                word_msg <= msg_reg;
            end
        end
    end

    // words are at least 17 bit times apart
    assert property (@(posedge clk) disable iff (rst) word_valid |=> !word_valid);

endmodule

// ==== src/td_shadow_regs.sv ====
/*
 * Time message shadow registers
 * assembles ToD, relative time and period fields from the word stream
 * and issues the period commit and the time loads at frame end
 */
`timescale 1ns/1ps

module td_shadow_regs import ptp_td_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  td_word_t  word_data,
    input  td_index_t word_index,
    input  td_msg_t   word_msg,
    input  logic      word_last,
    input  logic      word_valid,
    output period_t   period,
    output logic      rel_load,
    output rel_ns_t   rel_load_ns,
    output logic      tod_load,
    output tod_ns_t   tod_load_ns,
    output tod_s_t    tod_load_s
);

    rel_ns_t                 rel_ns_sh, rel_ns_nxt;
    tod_ns_t                 tod_ns_sh, tod_ns_nxt;
    tod_s_t                  tod_s_sh, tod_s_nxt;
    fns_t                    per_fns_sh, per_fns_nxt;
    logic [PERIOD_NS_W-1:0]  per_ns_sh, per_ns_nxt;
    logic                    rel_step_sh, rel_step_nxt;
    logic                    tod_step_sh, tod_step_nxt;
    logic [2:0]              rel_seen, rel_seen_nxt;
    logic [4:0]              tod_seen, tod_seen_nxt;
    logic [1:0]              per_seen, per_seen_nxt;
    logic                    rel_loaded;
    logic                    tod_loaded;
    logic                    time_word;
    logic                    frame_end;
    logic                    time_end;
    logic                    rel_go;
    logic                    tod_go;
    logic                    per_go;

    assign time_word = word_valid && (word_msg == MSG_TIME);
    assign frame_end = word_valid && word_last;
    assign time_end  = frame_end && (word_msg == MSG_TIME);

    // shadow contents including the word on the bus this cycle
    always_comb begin
        rel_ns_nxt   = rel_ns_sh;
        tod_ns_nxt   = tod_ns_sh;
        tod_s_nxt    = tod_s_sh;
        per_fns_nxt  = per_fns_sh;
        per_ns_nxt   = per_ns_sh;
        rel_step_nxt = rel_step_sh;
        tod_step_nxt = tod_step_sh;
        rel_seen_nxt = rel_seen;
        tod_seen_nxt = tod_seen;
        per_seen_nxt = per_seen;

        if (time_word) begin
            case (word_index)
                IDX_HDR: rel_step_nxt = word_data[HDR_REL_STEP_BIT];
                IDX_TOD_NS_LO: begin
                    tod_ns_nxt[WORD_W-1:0] = word_data;
                    tod_seen_nxt[0] = 1'b1;
                end
                IDX_TOD_NS_HI: begin
                    tod_ns_nxt[TOD_NS_W-1:WORD_W] = word_data[TOD_NS_W-WORD_W-1:0];
                    tod_step_nxt = word_data[TOD_STEP_BIT];
                    tod_seen_nxt[1] = 1'b1;
                end
                IDX_TOD_S_0: begin
                    tod_s_nxt[0 +: WORD_W] = word_data;
                    tod_seen_nxt[2] = 1'b1;
                end
                IDX_TOD_S_1: begin
                    tod_s_nxt[WORD_W +: WORD_W] = word_data;
                    tod_seen_nxt[3] = 1'b1;
                end
                IDX_TOD_S_2: begin
                    tod_s_nxt[2*WORD_W +: WORD_W] = word_data;
                    tod_seen_nxt[4] = 1'b1;
                end
                IDX_REL_NS_0: begin
                    rel_ns_nxt[0 +: WORD_W] = word_data;
                    rel_seen_nxt[0] = 1'b1;
                end
                IDX_REL_NS_1: begin
                    rel_ns_nxt[WORD_W +: WORD_W] = word_data;
                    rel_seen_nxt[1] = 1'b1;
                end
                IDX_REL_NS_2: begin
                    rel_ns_nxt[2*WORD_W +: WORD_W] = word_data;
                    rel_seen_nxt[2] = 1'b1;
                end
                IDX_PERIOD_FNS: begin
                    per_fns_nxt = word_data;
                    per_seen_nxt[0] = 1'b1;
                end
                IDX_PERIOD_NS: begin
                    per_ns_nxt = word_data[PERIOD_NS_W-1:0];
                    per_seen_nxt[1] = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // first complete frame always loads, later ones only on a step
    assign per_go = time_end && (&per_seen_nxt);
    assign rel_go = time_end && (&rel_seen_nxt) && (rel_step_nxt || !rel_loaded);
    assign tod_go = time_end && (&tod_seen_nxt) && (tod_step_nxt || !tod_loaded);

    always_ff @(posedge clk) begin
        if (rst) begin
            rel_seen    <= '0;
            tod_seen    <= '0;
            per_seen    <= '0;
            rel_step_sh <= 1'b0;
            tod_step_sh <= 1'b0;
            rel_loaded  <= 1'b0;
            tod_loaded  <= 1'b0;
            period      <= '0;
            rel_load    <= 1'b0;
            tod_load    <= 1'b0;
        end else begin
            rel_load <= rel_go;
            tod_load <= tod_go;
            if (rel_go) begin
                rel_loaded <= 1'b1;
            end
            if (tod_go) begin
                tod_loaded <= 1'b1;
            end
            if (per_go) begin
                period <= {per_ns_nxt, per_fns_nxt};
            end
            if (frame_end) begin
                rel_seen    <= '0;
                tod_seen    <= '0;
                per_seen    <= '0;
                rel_step_sh <= 1'b0;
                tod_step_sh <= 1'b0;
            end else begin
                rel_seen    <= rel_seen_nxt;
                tod_seen    <= tod_seen_nxt;
                per_seen    <= per_seen_nxt;
                rel_step_sh <= rel_step_nxt;
                tod_step_sh <= tod_step_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        rel_ns_sh  <= rel_ns_nxt;
        tod_ns_sh  <= tod_ns_nxt;
        tod_s_sh   <= tod_s_nxt;
        per_fns_sh <= per_fns_nxt;
        per_ns_sh  <= per_ns_nxt;
    end

    // shadows stay stable while a load is pending
    assign rel_load_ns = rel_ns_sh;
    assign tod_load_ns = tod_ns_sh;
    assign tod_load_s  = tod_s_sh;

    // no new word may arrive while a load reads the shadows
    assert property (@(posedge clk) disable iff (rst)
        (rel_load || tod_load) |-> $past(word_valid && word_last) && !word_valid);

endmodule

// ==== src/ts_rel_counter.sv ====
/*
 * Relative timestamp counter
 * accumulates the period into ns and fractional ns, or loads a new time
 */
`timescale 1ns/1ps

module ts_rel_counter import ptp_td_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  period_t              period,
    input  logic                 rel_load,
    input  rel_ns_t              rel_load_ns,
    output rel_ns_t              ts_rel_ns,
    output fns_t                 ts_rel_fns,
    output logic                 ts_rel_step,
    output logic [PERIOD_NS_W:0] ns_adv
);

    fns_t fns_sum;
    logic frac_carry;

    // whole ns for this cycle, period integer part plus fraction carry
    always_comb begin
        {frac_carry, fns_sum} = {1'b0, ts_rel_fns} + {1'b0, period[FNS_W-1:0]};
        ns_adv = {1'b0, period[FNS_W +: PERIOD_NS_W]} + {{PERIOD_NS_W{1'b0}}, frac_carry};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_rel_ns   <= '0;
            ts_rel_fns  <= '0;
            ts_rel_step <= 1'b0;
        end else if (rel_load) begin
            ts_rel_ns   <= rel_load_ns;
            ts_rel_fns  <= '0;
            ts_rel_step <= 1'b1;
        end else begin
            ts_rel_ns   <= ts_rel_ns + REL_NS_W'(ns_adv);
            ts_rel_fns  <= fns_sum;
            ts_rel_step <= 1'b0;
        end
    end

endmodule

// ==== src/ts_tod_counter.sv ====
/*
 * Time-of-day counter
 * advances ns by the relative counter's whole-ns step, rolls over
 * into seconds at one billion with a pps pulse, or loads a new time
 */
`timescale 1ns/1ps

module ts_tod_counter import ptp_td_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [PERIOD_NS_W:0] ns_adv,
    input  logic                 tod_load,
    input  tod_ns_t              tod_load_ns,
    input  tod_s_t               tod_load_s,
    output tod_ns_t              ts_tod_ns,
    output tod_s_t               ts_tod_s,
    output logic                 ts_tod_step,
    output logic                 pps
);

    logic [TOD_NS_W:0] ns_sum;
    logic              ns_wrap;

    // one spare bit so the sum cannot overflow before the compare
    assign ns_sum  = {1'b0, ts_tod_ns} + (TOD_NS_W+1)'(ns_adv);
    assign ns_wrap = ns_sum >= {1'b0, NS_PER_S};

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_tod_ns   <= '0;
            ts_tod_s    <= '0;
            ts_tod_step <= 1'b0;
            pps         <= 1'b0;
        end else if (tod_load) begin
            ts_tod_ns   <= tod_load_ns;
            ts_tod_s    <= tod_load_s;
            ts_tod_step <= 1'b1;
            pps         <= 1'b0;
        end else begin
            ts_tod_step <= 1'b0;
            if (ns_wrap) begin
                // second boundary
                ts_tod_ns <= tod_ns_t'(ns_sum - {1'b0, NS_PER_S});
                ts_tod_s  <= ts_tod_s + 48'd1;
                pps       <= 1'b1;
            end else begin
                ts_tod_ns <= tod_ns_t'(ns_sum);
                pps       <= 1'b0;
            end
        end
    end

    // holds as long as loaded ns values are in range
    assert property (@(posedge clk) disable iff (rst) ts_tod_ns < NS_PER_S);

endmodule

// ==== tests/td_tx_tasks.svh ====
/*
 * Serial time distribution transmit helpers
 * builds time frames and shifts them out on the line, one bit per clock
 */
`ifndef TD_TX_TASKS_SVH
`define TD_TX_TASKS_SVH

// words of the frame being sent
logic [15:0] frame_words [0:12];

task automatic send_bit(input logic b);
    @(posedge clk);
    ptp_td_sdi <= b;
endtask

// start bit, 16 data bits LSB first, next start or the stop bit
task automatic send_frame(input int n_words);
    for (int w = 0; w < n_words; w++) begin
        send_bit(1'b0);
        for (int b = 0; b < 16; b++) begin
            send_bit(frame_words[w][b]);
        end
    end
    // stop bit, line then stays high
    send_bit(1'b1);
endtask

task automatic make_time_frame(
    input td_msg_t msg,
    input logic    rel_step,
    input logic    tod_step,
    input rel_ns_t rel_ns,
    input tod_ns_t tod_ns,
    input tod_s_t  tod_s,
    input period_t per
);
    // header, type in 3..0 and relative step in bit 8
    frame_words[0]  = {7'd0, rel_step, 4'd0, msg};
    frame_words[1]  = tod_ns[15:0];
    frame_words[2]  = {tod_step, 1'b0, tod_ns[29:16]};
    frame_words[3]  = tod_s[15:0];
    frame_words[4]  = tod_s[31:16];
    frame_words[5]  = tod_s[47:32];
    // unused positions
    frame_words[6]  = 16'h0000;
    frame_words[7]  = 16'h0000;
    frame_words[8]  = rel_ns[15:0];
    frame_words[9]  = rel_ns[31:16];
    frame_words[10] = rel_ns[47:32];
    frame_words[11] = per[15:0];
    frame_words[12] = {8'h00, per[23:16]};
endtask

`endif

// ==== tests/tb_ptp_td_leaf.sv ====
/*
 * Testbench for the PTP time distribution leaf
 * sends serial time frames and checks loads, steps, counter progression and pps
 */
`timescale 1ns/1ps

module tb_ptp_td_leaf import ptp_td_pkg::*; ();

    localparam int          SDI_PIPELINE  = 2;
    localparam int          CLK_PERIOD    = 20;
    localparam int          FRAME_BITS    = 230;
    localparam int          MAX_FRAMES    = 40;
    localparam int          WATCHDOG_NS   = MAX_FRAMES * FRAME_BITS * CLK_PERIOD * 2;
    localparam int          STEP_LAT      = SDI_PIPELINE + 3;
    localparam int          STEP_TIMEOUT  = 4 * STEP_LAT;
    localparam logic [31:0] ONE_SECOND_NS = 32'd1_000_000_000;

    logic    clk = 1'b0;
    logic    rst;
    logic    ptp_td_sdi;
    rel_ns_t ts_rel;
    fns_t    ts_rel_fns;
    logic    ts_rel_step;
    tod_ns_t ts_tod_ns;
    tod_s_t  ts_tod_s;
    logic    ts_tod_step;
    logic    pps;

    integer  seed   = 57;
    int      errors = 0;
    // period the DUT should be running with
    period_t exp_period = '0;
    rel_ns_t prev_rel;
    fns_t    prev_fns;
    tod_ns_t prev_tod_ns;
    tod_s_t  prev_tod_s;

    `include "td_tx_tasks.svh"

    ptp_td_leaf #(
        .SDI_PIPELINE(SDI_PIPELINE)
    ) ptp_td_leaf_inst (
        .clk         (clk),
        .rst         (rst),
        .ptp_td_sdi  (ptp_td_sdi),
        .ts_rel      (ts_rel),
        .ts_rel_fns  (ts_rel_fns),
        .ts_rel_step (ts_rel_step),
        .ts_tod_ns   (ts_tod_ns),
        .ts_tod_s    (ts_tod_s),
        .ts_tod_step (ts_tod_step),
        .pps         (pps)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %0h actual %0h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic sample_prev();
        prev_rel    = ts_rel;
        prev_fns    = ts_rel_fns;
        prev_tod_ns = ts_tod_ns;
        prev_tod_s  = ts_tod_s;
    endtask

    // each cycle adds the period, ToD follows with the whole ns and wraps at one second
    task automatic check_progress(input string name, input int cycles);
        logic [16:0] fns_sum;
        logic [8:0]  adv;
        logic [31:0] tod_sum;
        logic [63:0] exp_tod_ns;
        logic [63:0] exp_tod_s;
        logic        exp_pps;
        @(negedge clk);
        sample_prev();
        for (int i = 0; i < cycles; i++) begin
            fns_sum = {1'b0, prev_fns} + {1'b0, exp_period[15:0]};
            adv     = {1'b0, exp_period[23:16]} + {8'd0, fns_sum[16]};
            tod_sum = 32'(prev_tod_ns) + 32'(adv);
            exp_pps = (tod_sum >= ONE_SECOND_NS);
            exp_tod_ns = exp_pps ? 64'(tod_sum - ONE_SECOND_NS) : 64'(tod_sum);
            exp_tod_s  = exp_pps ? 64'(prev_tod_s) + 64'd1 : 64'(prev_tod_s);
            @(negedge clk);
            check_value(name, "ts_rel", 64'(prev_rel) + 64'(adv), 64'(ts_rel));
            check_value(name, "ts_rel_fns", 64'(fns_sum[15:0]), 64'(ts_rel_fns));
            check_value(name, "ts_tod_ns", exp_tod_ns, 64'(ts_tod_ns));
            check_value(name, "ts_tod_s", exp_tod_s, 64'(ts_tod_s));
            check_value(name, "pps", 64'(exp_pps), 64'(pps));
            check_value(name, "steps", 64'd0, {62'd0, ts_rel_step, ts_tod_step});
            sample_prev();
        end
    endtask

    // waits for a step pulse, then checks the loaded values and that it lasts one cycle
    task automatic check_step(input string name, input rel_ns_t rel_ns,
                              input tod_ns_t tod_ns, input tod_s_t tod_s);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(ts_rel_step || ts_tod_step) && waited < STEP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (ts_rel_step || ts_tod_step) else begin
            $display("ERROR %s: no step pulse within %0d cycles of the stop bit",
                     name, STEP_TIMEOUT);
            errors++;
        end
        check_value(name, "steps", 64'd3, {62'd0, ts_rel_step, ts_tod_step});
        check_value(name, "ts_rel", 64'(rel_ns), 64'(ts_rel));
        check_value(name, "ts_rel_fns", 64'd0, 64'(ts_rel_fns));
        check_value(name, "ts_tod_ns", 64'(tod_ns), 64'(ts_tod_ns));
        check_value(name, "ts_tod_s", 64'(tod_s), 64'(ts_tod_s));
        @(negedge clk);
        check_value(name, "steps after", 64'd0, {62'd0, ts_rel_step, ts_tod_step});
    endtask

    task automatic idle_after_reset();
        repeat (40) begin
            @(negedge clk);
            check_value("idle_after_reset", "ts_rel", 64'd0, 64'(ts_rel));
            check_value("idle_after_reset", "ts_rel_fns", 64'd0, 64'(ts_rel_fns));
            check_value("idle_after_reset", "ts_tod_ns", 64'd0, 64'(ts_tod_ns));
            check_value("idle_after_reset", "ts_tod_s", 64'd0, 64'(ts_tod_s));
            check_value("idle_after_reset", "steps and pps", 64'd0,
                        {61'd0, ts_rel_step, ts_tod_step, pps});
        end
    endtask

    // first complete frame loads even without step flags
    task automatic first_load();
        rel_ns_t rel_ns;
        tod_ns_t tod_ns;
        tod_s_t  tod_s;
        rel_ns = rel_ns_t'({$random(seed), $random(seed)});
        tod_ns = tod_ns_t'({$random(seed)} % ONE_SECOND_NS);
        tod_s  = tod_s_t'({$random(seed), $random(seed)});
        make_time_frame(MSG_TIME, 1'b0, 1'b0, rel_ns, tod_ns, tod_s, '0);
        send_frame(13);
        check_step("first_load", rel_ns, tod_ns, tod_s);
    endtask

    task automatic period_advance();
        period_t per;
        per = {8'd8, 16'($random(seed))};
        make_time_frame(MSG_TIME, 1'b0, 1'b0, '0, '0, '0, per);
        send_frame(13);
        // period commits one cycle before a step would show
        repeat (STEP_LAT + 1) @(posedge clk);
        exp_period = per;
        check_progress("period_advance", 24);
    endtask

    task automatic no_step_then_step();
        rel_ns_t rel_ns;
        tod_ns_t tod_ns;
        tod_s_t  tod_s;
        rel_ns = rel_ns_t'({$random(seed), $random(seed)});
        tod_ns = tod_ns_t'({$random(seed)} % ONE_SECOND_NS);
        tod_s  = tod_s_t'({$random(seed), $random(seed)});
        make_time_frame(MSG_TIME, 1'b0, 1'b0, rel_ns, tod_ns, tod_s, exp_period);
        send_frame(13);
        check_progress("no_step", STEP_LAT + 8);
        // fresh values, now with both step flags
        rel_ns = rel_ns_t'({$random(seed), $random(seed)});
        tod_ns = tod_ns_t'({$random(seed)} % ONE_SECOND_NS);
        tod_s  = tod_s_t'({$random(seed), $random(seed)});
        make_time_frame(MSG_TIME, 1'b1, 1'b1, rel_ns, tod_ns, tod_s, exp_period);
        send_frame(13);
        check_step("step_reload", rel_ns, tod_ns, tod_s);
        check_progress("after_reload", 6);
    endtask

    task automatic other_msg_ignored();
        make_time_frame(4'd1, 1'b1, 1'b1, rel_ns_t'(48'h1234_5678_9abc),
                        tod_ns_t'(30'd777), tod_s_t'(48'd42), {8'd3, 16'h1234});
        send_frame(13);
        check_progress("other_msg_ignored", STEP_LAT + 8);
    endtask

    task automatic pps_rollover();
        tod_s_t tod_s;
        int     pulses;
        pulses = 0;
        tod_s  = tod_s_t'({$random(seed), $random(seed)});
        exp_period = {8'd10, 16'h0000};
        // three and a half periods below the second boundary
        make_time_frame(MSG_TIME, 1'b1, 1'b1, '0, tod_ns_t'(ONE_SECOND_NS - 32'd35), tod_s,
                        exp_period);
        send_frame(13);
        check_step("pps_load", '0, tod_ns_t'(ONE_SECOND_NS - 32'd35), tod_s);
        sample_prev();
        repeat (12) begin
            @(negedge clk);
            if (pps) begin
                pulses++;
                check_value("pps_rollover", "ts_tod_s", 64'(prev_tod_s) + 64'd1,
                            64'(ts_tod_s));
                check_value("pps_rollover", "ts_tod_ns",
                            64'(prev_tod_ns) + 64'd10 - 64'(ONE_SECOND_NS), 64'(ts_tod_ns));
            end
            sample_prev();
        end
        check_value("pps_rollover", "pps pulses", 64'd1, 64'(pulses));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        ptp_td_sdi = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        idle_after_reset();
        first_load();
        period_advance();
        no_step_then_step();
        other_msg_ignored();
        pps_rollover();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
